/* filelist.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_loader.sv
logic/rv_fetch.sv
logic/rv_execute.sv
logic/rv_memory.sv
logic/rv_top.sv
bench/rv_top_asserts.sv
bench/rv_top_tb.sv

/* Bender.yml */
package:
  name: rv_subsystem

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_pkg.sv
      - logic/rv_loader.sv
      - logic/rv_fetch.sv
      - logic/rv_execute.sv
      - logic/rv_memory.sv
      - logic/rv_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/rv_top_asserts.sv
      - bench/rv_top_tb.sv

/* bench/rv_top_tb.sv */
// Testbench for rv_top with load tasks, reference model, directed tests and summary
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_top_tb;

	// Five programs of at most 34 loaded words each, about 4 cycles per handshake
	// Reset, idle checks and run time keep the total near 1000 cycles
	localparam int MAX_CYCLES = 4000;
	localparam int DMEM_WORDS = 2 ** `RV_DMEM_AW;

	logic tb_CLK;
	logic reset;
	logic load_req;
	rv_pkg::load_cmd_t load_cmd;
	logic load_ack;
	logic store_valid;
	rv_pkg::store_rpt_t store_rpt;
	rv_pkg::word_t retired;
	logic halted;

	integer seed = 32'he270cef3;
	int errors = 0;
	int stores_seen = 0;
	int cycles = 0;
	logic started;

	// Program, data preload, observed and expected stores
	rv_pkg::word_t prog [$];
	rv_pkg::word_t dinit [DMEM_WORDS];
	rv_pkg::store_rpt_t got_q [$];
	rv_pkg::store_rpt_t exp_q [$];
	int unsigned exp_retired;

	rv_top rv_top_i (
		.clk         (tb_CLK),
		.reset       (reset),
		.load_req    (load_req),
		.load_cmd    (load_cmd),
		.load_ack    (load_ack),
		.store_valid (store_valid),
		.store_rpt   (store_rpt),
		.retired     (retired),
		.halted      (halted)
	);

	initial begin
		tb_CLK = 1'b0;
		forever #10 tb_CLK = ~tb_CLK;
	end

	// Hard limit on run length
	always @(posedge tb_CLK) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped at %0t: no result after %0d cycles", $time, MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Store reports sampled mid-cycle
	always @(negedge tb_CLK) begin
		if (!reset && store_valid !== 1'b0) begin
			if (!started) begin
				protocol_error("store reported before the start command");
			end else begin
				got_q.push_back(store_rpt);
			end
		end
	end

	task automatic value_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic protocol_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// Instruction encoders, RV32I formats
	function automatic rv_pkg::word_t addi(input rv_pkg::reg_idx_t rd,
			input rv_pkg::reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, `RV_OPC_OPIMM};
	endfunction

	function automatic rv_pkg::word_t add_sub(input logic sub, input rv_pkg::reg_idx_t rd,
			input rv_pkg::reg_idx_t rs1, input rv_pkg::reg_idx_t rs2);
		return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, `RV_OPC_OP};
	endfunction

	function automatic rv_pkg::word_t lui(input rv_pkg::reg_idx_t rd, input logic [19:0] imm);
		return {imm, rd, `RV_OPC_LUI};
	endfunction

	function automatic rv_pkg::word_t lw(input rv_pkg::reg_idx_t rd,
			input rv_pkg::reg_idx_t rs1, input logic [11:0] imm);
		return {imm, rs1, `RV_F3_WORD, rd, `RV_OPC_LOAD};
	endfunction

	function automatic rv_pkg::word_t sw(input rv_pkg::reg_idx_t rs2,
			input rv_pkg::reg_idx_t rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, `RV_F3_WORD, imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic rv_pkg::word_t ebreak();
		return {12'h001, 5'd0, 3'b000, 5'd0, `RV_OPC_SYSTEM};
	endfunction

	task automatic apply_reset();
		@(posedge tb_CLK);
		#2;
		reset = 1'b1;
		load_req = 1'b0;
		started = 1'b0;
		repeat (10) @(posedge tb_CLK);
		#2;
		reset = 1'b0;
	endtask

	// One four-phase handshake
	task automatic load_word(input rv_pkg::load_kind_e kind, input int addr,
			input rv_pkg::word_t data);
		int wait_n;
		@(posedge tb_CLK);
		#2;
		if (load_ack !== 1'b0) begin
			protocol_error("load_ack still high before a new request");
		end
		load_cmd.kind = kind;
		load_cmd.addr = rv_pkg::load_addr_t'(addr);
		load_cmd.data = data;
		load_req = 1'b1;
		wait_n = 0;
		do begin
			@(negedge tb_CLK);
			wait_n++;
		end while (load_ack !== 1'b1 && wait_n < 4);
		if (load_ack !== 1'b1) begin
			protocol_error("load_ack did not rise after load_req");
		end else if (wait_n < 2) begin
			protocol_error("load_ack rose before the loader could see load_req");
		end
		@(posedge tb_CLK);
		#2;
		load_req = 1'b0;
		wait_n = 0;
		do begin
			@(negedge tb_CLK);
			wait_n++;
		end while (load_ack !== 1'b0 && wait_n < 4);
		if (load_ack !== 1'b0) begin
			protocol_error("load_ack did not fall after load_req dropped");
		end
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++) begin
			load_word(rv_pkg::load_imem, i, prog[i]);
		end
		for (i = 0; i < DMEM_WORDS; i++) begin
			load_word(rv_pkg::load_dmem, i, dinit[i]);
		end
		// Core stays parked with everything loaded
		repeat (3) @(negedge tb_CLK);
		if (retired !== '0 || halted !== 1'b0) begin
			protocol_error("core ran before the start command");
		end
		got_q.delete();
		started = 1'b1;
		load_word(rv_pkg::load_start, 0, '0);
	endtask

	// ISA-level model of the program on a private register file and memory
	task automatic run_model();
		rv_pkg::word_t r [32];
		rv_pkg::word_t m [DMEM_WORDS];
		rv_pkg::word_t ins;
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t ea;
		rv_pkg::store_rpt_t s;
		int i;
		int pc;
		logic done;
		exp_q.delete();
		exp_retired = 0;
		for (i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		for (i = 0; i < DMEM_WORDS; i++) begin
			m[i] = dinit[i];
		end
		pc = 0;
		done = 1'b0;
		while (!done && pc < prog.size()) begin
			ins = prog[pc];
			a = r[ins[19:15]];
			b = r[ins[24:20]];
			exp_retired++;
			case (ins[6:0])
				`RV_OPC_OP: begin
					if (ins[14:12] == 3'b000) begin
						r[ins[11:7]] = ins[30] ? a - b : a + b;
					end
				end
				`RV_OPC_OPIMM: begin
					if (ins[14:12] == 3'b000) begin
						r[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
					end
				end
				`RV_OPC_LUI: r[ins[11:7]] = {ins[31:12], 12'b0};
				`RV_OPC_LOAD: begin
					// Word index of the byte address, memory wraps at its depth
					ea = a + {{20{ins[31]}}, ins[31:20]};
					r[ins[11:7]] = m[(ea >> 2) % DMEM_WORDS];
				end
				`RV_OPC_STORE: begin
					ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					m[(ea >> 2) % DMEM_WORDS] = b;
					s.addr = rv_pkg::dmem_addr_t'((ea >> 2) % DMEM_WORDS);
					s.data = b;
					exp_q.push_back(s);
				end
				`RV_OPC_SYSTEM: done = (ins == ebreak());
				default: ;
			endcase
			r[0] = '0;
			pc++;
		end
	endtask

	// Waits for halted, then watches a few more cycles for stray stores
	task automatic run_and_collect();
		int after;
		after = 0;
		while (after < 6) begin
			@(negedge tb_CLK);
			if (halted === 1'b1) begin
				after++;
			end
		end
	endtask

	task automatic compare(input string name);
		int i;
		int n;
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		if (got_q.size() != exp_q.size()) begin
			value_error($sformatf("%s: %0d stores reported, expected %0d",
				name, got_q.size(), exp_q.size()));
		end
		for (i = 0; i < n; i++) begin
			if (got_q[i] !== exp_q[i]) begin
				value_error($sformatf("%s: store %0d word %0d data %h, expected word %0d data %h",
					name, i, got_q[i].addr, got_q[i].data, exp_q[i].addr, exp_q[i].data));
			end
		end
		stores_seen += n;
		if (retired !== exp_retired) begin
			value_error($sformatf("%s: retired %0d, expected %0d", name, retired, exp_retired));
		end
		if (halted !== 1'b1) begin
			value_error($sformatf("%s: halted %b, expected 1", name, halted));
		end
	endtask

	task automatic run_program(input string name);
		apply_reset();
		@(negedge tb_CLK);
		if (load_ack !== 1'b0 || halted !== 1'b0 || retired !== '0) begin
			value_error($sformatf("%s: after reset load_ack %b halted %b retired %0d, expected zeros",
				name, load_ack, halted, retired));
		end
		load_program();
		run_model();
		run_and_collect();
		compare(name);
	endtask

	// Random preload, a fresh pattern for every word
	task automatic fill_dmem();
		int i;
		for (i = 0; i < DMEM_WORDS; i++) begin
			dinit[i] = $random(seed);
		end
	endtask

	task automatic handshake_test();
		prog.delete();
		fill_dmem();
		prog.push_back(addi(5'd1, 5'd0, 12'h07b));
		prog.push_back(sw(5'd1, 5'd0, 12'd4));
		prog.push_back(ebreak());
		run_program("handshake");
	endtask

	// Each instruction consumes the previous result
	task automatic alu_chain_test();
		logic [11:0] i1;
		logic [11:0] i2;
		logic [11:0] i3;
		logic [19:0] u;
		i1 = $random(seed);
		i2 = $random(seed);
		i3 = $random(seed);
		u = $random(seed);
		prog.delete();
		fill_dmem();
		prog.push_back(addi(5'd1, 5'd0, i1));
		prog.push_back(addi(5'd2, 5'd1, i2));
		prog.push_back(add_sub(1'b0, 5'd3, 5'd2, 5'd1));
		prog.push_back(add_sub(1'b1, 5'd4, 5'd3, 5'd2));
		prog.push_back(lui(5'd5, u));
		prog.push_back(add_sub(1'b0, 5'd6, 5'd5, 5'd4));
		prog.push_back(add_sub(1'b1, 5'd7, 5'd4, 5'd6));
		prog.push_back(addi(5'd8, 5'd7, i3));
		prog.push_back(sw(5'd8, 5'd0, 12'd28));
		prog.push_back(sw(5'd1, 5'd0, 12'd0));
		prog.push_back(sw(5'd2, 5'd0, 12'd4));
		prog.push_back(sw(5'd3, 5'd0, 12'd8));
		prog.push_back(sw(5'd4, 5'd0, 12'd12));
		prog.push_back(sw(5'd5, 5'd0, 12'd16));
		prog.push_back(sw(5'd6, 5'd0, 12'd20));
		prog.push_back(sw(5'd7, 5'd0, 12'd24));
		prog.push_back(ebreak());
		run_program("alu_chain");
	endtask

	// LW directly followed by a consumer of the loaded register
	task automatic load_use_test();
		int ka;
		int kb;
		logic [11:0] imm;
		imm = $random(seed);
		prog.delete();
		fill_dmem();
		repeat (4) begin
			ka = $random(seed) & 15;
			kb = $random(seed) & 15;
			prog.push_back(lw(5'd1, 5'd0, 12'(ka * 4)));
			prog.push_back(sw(5'd1, 5'd0, 12'(kb * 4)));
		end
		// Base register plus offset, loaded value into the ALU
		prog.push_back(addi(5'd2, 5'd0, 12'd8));
		prog.push_back(lw(5'd3, 5'd2, 12'd20));
		prog.push_back(addi(5'd4, 5'd3, imm));
		prog.push_back(sw(5'd4, 5'd2, 12'd0));
		prog.push_back(ebreak());
		run_program("load_use");
	endtask

	task automatic x0_write_test();
		logic [11:0] imm;
		imm = $random(seed) | 1;
		prog.delete();
		fill_dmem();
		prog.push_back(addi(5'd0, 5'd0, imm));
		prog.push_back(sw(5'd0, 5'd0, 12'd0));
		prog.push_back(lui(5'd0, 20'habcde));
		prog.push_back(sw(5'd0, 5'd0, 12'd4));
		prog.push_back(addi(5'd1, 5'd0, 12'd0));
		prog.push_back(sw(5'd1, 5'd0, 12'd8));
		prog.push_back(lw(5'd0, 5'd0, 12'd12));
		prog.push_back(sw(5'd0, 5'd0, 12'd12));
		prog.push_back(ebreak());
		run_program("x0_writes");
	endtask

	// Unknown opcode as a no-op, then code past EBREAK that must not run
	task automatic halt_test();
		prog.delete();
		fill_dmem();
		prog.push_back(addi(5'd1, 5'd0, 12'h321));
		prog.push_back(32'h0000000f);
		prog.push_back(sw(5'd1, 5'd0, 12'd0));
		prog.push_back(ebreak());
		prog.push_back(sw(5'd1, 5'd0, 12'd4));
		prog.push_back(addi(5'd2, 5'd1, 12'd1));
		prog.push_back(sw(5'd2, 5'd0, 12'd8));
		prog.push_back(ebreak());
		run_program("halt");
	endtask

	initial begin
		reset = 1'b1;
		load_req = 1'b0;
		load_cmd = '0;
		started = 1'b0;
		handshake_test();
		alu_chain_test();
		load_use_test();
		x0_write_test();
		halt_test();
		// Assertion failures in the bound checker count as errors too
		errors += rv_top_i.rv_top_asserts_i.fails;
		$display("Summary: %0d errors, %0d stores compared", errors, stores_seen);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* bench/rv_top_asserts.sv */
// Concurrent assertions on the load handshake and store reporting, bound into rv_top
`timescale 1ns/1ps

module rv_top_asserts (
	input logic clk,
	input logic reset,
	input logic load_req,
	input logic load_ack,
	input logic store_valid,
	input logic halted
);

	// Number of assertion failures so far
	int fails = 0;

	// Ack only answers a request sampled on the previous edge
	property ack_follows_req;
		@(posedge clk) disable iff (reset)
		$rose(load_ack) |-> $past(load_req);
	endproperty

	// Ack drops only once req has gone low
	property ack_drops_after_req;
		@(posedge clk) disable iff (reset)
		$fell(load_ack) |-> !$past(load_req);
	endproperty

	// Nothing stores once the core has been halted for a full cycle
	property quiet_after_halt;
		@(posedge clk) disable iff (reset)
		(halted && $past(halted)) |-> !store_valid;
	endproperty

	assert property (ack_follows_req)
		else begin
			$error("load_ack rose without load_req");
			fails++;
		end

	assert property (ack_drops_after_req)
		else begin
			$error("load_ack fell while load_req was still high");
			fails++;
		end

	assert property (quiet_after_halt)
		else begin
			$error("store_valid high after the core halted");
			fails++;
		end

endmodule

bind rv_top rv_top_asserts rv_top_asserts_i (
	.clk         (clk),
	.reset       (reset),
	.load_req    (load_req),
	.load_ack    (load_ack),
	.store_valid (store_valid),
	.halted      (halted)
);

/* logic/rv_top.sv */
// Top level with the load port FSM and the three pipeline stages
`timescale 1ns/1ps

module rv_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                load_req,
	input  rv_pkg::load_cmd_t   load_cmd,
	output logic                load_ack,
	output logic                store_valid,
	output rv_pkg::store_rpt_t  store_rpt,
	output rv_pkg::word_t       retired,
	output logic                halted
);

	// Loader to memories and core release
	logic run;
	logic imem_we;
	rv_pkg::imem_addr_t imem_waddr;
	rv_pkg::word_t imem_wdata;
	logic dmem_we;
	rv_pkg::dmem_addr_t dmem_waddr;
	rv_pkg::word_t dmem_wdata;

	// Pipeline links
	rv_pkg::fetch_out_t fetch_out;
	rv_pkg::exec_out_t exec_out;
	rv_pkg::fwd_t fwd;
	logic stop;

	rv_loader rv_loader_i (
		.clk        (clk),
		.reset      (reset),
		.load_req   (load_req),
		.load_cmd   (load_cmd),
		.load_ack   (load_ack),
		.run        (run),
		.imem_we    (imem_we),
		.imem_waddr (imem_waddr),
		.imem_wdata (imem_wdata),
		.dmem_we    (dmem_we),
		.dmem_waddr (dmem_waddr),
		.dmem_wdata (dmem_wdata)
	);

	rv_fetch rv_fetch_i (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.stop       (stop),
		.imem_we    (imem_we),
		.imem_waddr (imem_waddr),
		.imem_wdata (imem_wdata),
		.fetch_out  (fetch_out)
	);

	rv_execute rv_execute_i (
		.clk      (clk),
		.reset    (reset),
		.fetch_in (fetch_out),
		.fwd      (fwd),
		.exec_out (exec_out),
		.stop     (stop)
	);

	rv_memory rv_memory_i (
		.clk         (clk),
		.reset       (reset),
		.exec_in     (exec_out),
		.dmem_we     (dmem_we),
		.dmem_waddr  (dmem_waddr),
		.dmem_wdata  (dmem_wdata),
		.fwd         (fwd),
		.store_valid (store_valid),
		.store_rpt   (store_rpt),
		.retired     (retired),
		.halted      (halted)
	);

endmodule

/* logic/rv_memory.sv */
// Data memory, writeback and forwarding, store report, retire counter and halt flag
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_memory (
	input  logic                clk,
	input  logic                reset,
	input  rv_pkg::exec_out_t   exec_in,
	input  logic                dmem_we,
	input  rv_pkg::dmem_addr_t  dmem_waddr,
	input  rv_pkg::word_t       dmem_wdata,
	output rv_pkg::fwd_t        fwd,
	output logic                store_valid,
	output rv_pkg::store_rpt_t  store_rpt,
	output rv_pkg::word_t       retired,
	output logic                halted
);

	rv_pkg::word_t dmem [2**`RV_DMEM_AW];
	rv_pkg::dmem_addr_t addr;
	rv_pkg::word_t load_data;

	// Byte address from execute, word index into the memory
	assign addr = exec_in.result[`RV_DMEM_AW+1:2];

	// Asynchronous read so LW data is ready in its own memory cycle
	assign load_data = dmem[addr];

	assign store_valid = exec_in.valid & exec_in.is_store;

	// Loader port first, then SW from the pipeline
	// The two never overlap since loading ends before run
	always_ff @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_waddr] <= dmem_wdata;
		end else if (store_valid) begin
			dmem[addr] <= exec_in.store_data;
		end
	end

	// Writeback value doubles as the forwarding source
	assign fwd.valid = exec_in.valid & exec_in.writes_rd;
	assign fwd.rd = exec_in.rd;
	assign fwd.value = exec_in.is_load ? load_data : exec_in.result;

	// Store report, qualified by store_valid
	assign store_rpt.addr = addr;
	assign store_rpt.data = exec_in.store_data;

	// Every valid instruction retires here, EBREAK included
	always_ff @(posedge clk) begin
		if (reset) begin
			retired <= '0;
		end else if (exec_in.valid) begin
			retired <= retired + 32'd1;
		end
	end

	// Set as EBREAK retires, so retired is final once halted is seen
	always_ff @(posedge clk) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (exec_in.valid && exec_in.is_halt) begin
			halted <= 1'b1;
		end
	end

endmodule

/* logic/rv_execute.sv */
// Decode, register file, forwarding, ALU and execute pipeline register
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_execute (
	input  logic                clk,
	input  logic                reset,
	input  rv_pkg::fetch_out_t  fetch_in,
	input  rv_pkg::fwd_t        fwd,
	output rv_pkg::exec_out_t   exec_out,
	output logic                stop
);

	rv_pkg::word_t regs [32];

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic funct7_5;
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::reg_idx_t rd;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_u;
	rv_pkg::word_t imm;
	rv_pkg::word_t rs1_val;
	rv_pkg::word_t rs2_val;
	rv_pkg::word_t op_b;
	rv_pkg::word_t result;
	rv_pkg::alu_op_e alu_op;
	logic use_imm;
	logic dec_alu;
	logic dec_load;
	logic dec_store;
	logic dec_halt;
	logic halt_seen;
	rv_pkg::exec_out_t exec_d;

	// Instruction fields
	assign opcode = fetch_in.instr[6:0];
	assign funct3 = fetch_in.instr[14:12];
	assign funct7_5 = fetch_in.instr[30];
	assign rd = fetch_in.instr[11:7];
	assign rs1 = fetch_in.instr[19:15];
	assign rs2 = fetch_in.instr[24:20];

	// Sign-extended immediates
	assign imm_i = {{20{fetch_in.instr[31]}}, fetch_in.instr[31:20]};
	assign imm_s = {{20{fetch_in.instr[31]}}, fetch_in.instr[31:25], fetch_in.instr[11:7]};
	assign imm_u = {fetch_in.instr[31:12], 12'b0};

	// Operand read, x0 hardwired to zero
	// Memory stage result wins over the stale register file entry
	assign rs1_val = (rs1 == '0) ? '0 :
		(fwd.valid && fwd.rd == rs1) ? fwd.value : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
		(fwd.valid && fwd.rd == rs2) ? fwd.value : regs[rs2];

	// Decode of the supported subset
	// Anything else falls through as a no-op
	always_comb begin
		dec_alu = 1'b0;
		dec_load = 1'b0;
		dec_store = 1'b0;
		dec_halt = 1'b0;
		use_imm = 1'b0;
		imm = imm_i;
		alu_op = rv_pkg::alu_add;
		case (opcode)
			`RV_OPC_OP: begin
				if (funct3 == 3'b000) begin
					dec_alu = 1'b1;
					alu_op = funct7_5 ? rv_pkg::alu_sub : rv_pkg::alu_add;
				end
			end
			`RV_OPC_OPIMM: begin
				// ADDI only
				if (funct3 == 3'b000) begin
					dec_alu = 1'b1;
					use_imm = 1'b1;
				end
			end
			`RV_OPC_LUI: begin
				dec_alu = 1'b1;
				use_imm = 1'b1;
				imm = imm_u;
				alu_op = rv_pkg::alu_pass_imm;
			end
			`RV_OPC_LOAD: begin
				// Address is rs1 + imm_i
				if (funct3 == `RV_F3_WORD) begin
					dec_load = 1'b1;
					use_imm = 1'b1;
				end
			end
			`RV_OPC_STORE: begin
				if (funct3 == `RV_F3_WORD) begin
					dec_store = 1'b1;
					use_imm = 1'b1;
					imm = imm_s;
				end
			end
			`RV_OPC_SYSTEM: begin
				dec_halt = (fetch_in.instr == `RV_INSTR_EBREAK);
			end
			default: ;
		endcase
	end

	// ALU, also forms load and store addresses
	assign op_b = use_imm ? imm : rs2_val;

	always_comb begin
		case (alu_op)
			rv_pkg::alu_sub: result = rs1_val - op_b;
			rv_pkg::alu_pass_imm: result = imm;
			default: result = rs1_val + op_b;
		endcase
	end

	// Next contents of the execute register
	always_comb begin
		exec_d.valid = fetch_in.valid;
		exec_d.is_load = dec_load;
		exec_d.is_store = dec_store;
		exec_d.is_halt = dec_halt;
		exec_d.writes_rd = dec_alu | dec_load;
		exec_d.rd = rd;
		exec_d.result = result;
		exec_d.store_data = rs2_val;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exec_out.valid <= 1'b0;
		end else begin
			exec_out <= exec_d;
		end
	end

	// Stop is immediate on EBREAK decode, then held
	assign stop = halt_seen | (fetch_in.valid & dec_halt);

	always_ff @(posedge clk) begin
		if (reset) begin
			halt_seen <= 1'b0;
		end else if (fetch_in.valid && dec_halt) begin
			halt_seen <= 1'b1;
		end
	end

	// Writeback port, fed by the memory stage
	always_ff @(posedge clk) begin
		if (fwd.valid && fwd.rd != '0) begin
			regs[fwd.rd] <= fwd.value;
		end
	end

endmodule

/* logic/rv_fetch.sv */
// Instruction memory, program counter and fetch pipeline register
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_fetch (
	input  logic                clk,
	input  logic                reset,
	input  logic                run,
	input  logic                stop,
	input  logic                imem_we,
	input  rv_pkg::imem_addr_t  imem_waddr,
	input  rv_pkg::word_t       imem_wdata,
	output rv_pkg::fetch_out_t  fetch_out
);

	rv_pkg::word_t imem [2**`RV_IMEM_AW];
	rv_pkg::imem_addr_t pc;
	logic issue;

	// One instruction per cycle once released, none after EBREAK
	assign issue = run & ~stop;

	// Loader write port
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_waddr] <= imem_wdata;
		end
	end

	// Word-addressed PC, starts at word 0
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (issue) begin
			pc <= pc + 1'b1;
		end
	end

	// Combinational read at pc, registered into the fetch stage
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_out.valid <= 1'b0;
		end else begin
			// Stop squashes the word being read this cycle
			fetch_out.valid <= issue;
			fetch_out.pc <= pc;
			fetch_out.instr <= imem[pc];
		end
	end

endmodule

/* logic/rv_loader.sv */
// Four-phase req/ack load port FSM writing both memories and releasing the core
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_loader (
	input  logic                clk,
	input  logic                reset,
	input  logic                load_req,
	input  rv_pkg::load_cmd_t   load_cmd,
	output logic                load_ack,
	output logic                run,
	output logic                imem_we,
	output rv_pkg::imem_addr_t  imem_waddr,
	output rv_pkg::word_t       imem_wdata,
	output logic                dmem_we,
	output rv_pkg::dmem_addr_t  dmem_waddr,
	output rv_pkg::word_t       dmem_wdata
);

	rv_pkg::loader_state_e state;
	logic accept;

	// New request seen while idle
	assign accept = (state == rv_pkg::ld_idle) && load_req;

	// Ack follows the state, so it rises and falls one cycle after req
	assign load_ack = (state == rv_pkg::ld_ack);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rv_pkg::ld_idle;
			run <= 1'b0;
			imem_we <= 1'b0;
			dmem_we <= 1'b0;
		end else begin
			// Enables are single-cycle pulses
			imem_we <= 1'b0;
			dmem_we <= 1'b0;
			case (state)
				rv_pkg::ld_idle: begin
					if (load_req) begin
						state <= rv_pkg::ld_ack;
						imem_we <= (load_cmd.kind == rv_pkg::load_imem);
						dmem_we <= (load_cmd.kind == rv_pkg::load_dmem);
						// Run is sticky until reset
						if (load_cmd.kind == rv_pkg::load_start) begin
							run <= 1'b1;
						end
					end
				end
				rv_pkg::ld_ack: begin
					// Wait for req to drop before taking the next word
					if (!load_req) begin
						state <= rv_pkg::ld_idle;
					end
				end
				default: state <= rv_pkg::ld_idle;
			endcase
		end
	end

	// Address and data captured alongside the enable
	always_ff @(posedge clk) begin
		if (accept) begin
			imem_waddr <= load_cmd.addr[`RV_IMEM_AW-1:0];
			imem_wdata <= load_cmd.data;
			dmem_waddr <= load_cmd.addr[`RV_DMEM_AW-1:0];
			dmem_wdata <= load_cmd.data;
		end
	end

endmodule

/* logic/rv_pkg.sv */
// Vector typedefs, enums and pipeline stage structs of the RV32I subset core
`include "rv_params.svh"

package rv_pkg;

	// Load address is wide enough for either memory
	localparam int LOAD_AW = (`RV_IMEM_AW > `RV_DMEM_AW) ? `RV_IMEM_AW : `RV_DMEM_AW;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;
	typedef logic [`RV_DMEM_AW-1:0] dmem_addr_t;
	typedef logic [LOAD_AW-1:0] load_addr_t;

	// Commands carried over the load port
	typedef enum logic [1:0] {
		load_imem,
		load_dmem,
		load_start
	} load_kind_e;

	typedef struct packed {
		load_kind_e kind;
		load_addr_t addr;
		word_t data;
	} load_cmd_t;

	typedef enum logic {
		ld_idle,
		ld_ack
	} loader_state_e;

	// Fetch to execute
	typedef struct packed {
		logic valid;
		imem_addr_t pc;
		word_t instr;
	} fetch_out_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_pass_imm
	} alu_op_e;

	// Execute to memory/writeback
	typedef struct packed {
		logic valid;
		logic is_load;
		logic is_store;
		logic is_halt;
		logic writes_rd;
		reg_idx_t rd;
		word_t result;
		word_t store_data;
	} exec_out_t;

	// Writeback and forwarding path back into execute
	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t value;
	} fwd_t;

	typedef struct packed {
		dmem_addr_t addr;
		word_t data;
	} store_rpt_t;

endpackage

/* logic/rv_params.svh */
// Memory depth and opcode macros for the RV32I subset core
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Word address widths of the two memories
`define RV_IMEM_AW 6
`define RV_DMEM_AW 4

// Major opcodes, bits 6:0 of the instruction
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_SYSTEM 7'b1110011

// funct3 of the word-sized load and store
`define RV_F3_WORD 3'b010
// Full EBREAK encoding
`define RV_INSTR_EBREAK 32'h00100073

`endif
